// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // data path and register file sizes
    localparam int xlen          = 32;
    localparam int num_regs      = 32;
    localparam int reg_sel_width = 5;

    typedef logic [xlen-1:0]          word_t;
    typedef logic [reg_sel_width-1:0] reg_sel_t;

    localparam word_t reset_pc = 32'd0;

    // memory-mapped store addresses, never reach the memory port
    localparam word_t out_addr  = 32'd1000;
    localparam word_t halt_addr = 32'd1004;

    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111
    } opcode_e;

    // alu funct3, shared by op and op_imm
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // selects sub and sra
    localparam logic [6:0] f7_alt = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        reg_sel_t   rs2;
        reg_sel_t   rs1;
        logic [2:0] funct3;
        reg_sel_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_sel_t    rs1;
        logic [2:0]  funct3;
        reg_sel_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_sel_t   rs2;
        reg_sel_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_sel_t   rs2;
        reg_sel_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_sel_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_sel_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

endpackage

`default_nettype wire

// File: common/proc_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// request held until a single-cycle ack, rdata valid with ack
interface mem_bus_if import rv_pkg::*; ();
    logic  rd_req;
    logic  wr_req;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  ack;

    modport requester (
        output rd_req, wr_req, addr, wdata,
        input  rdata, ack
    );

    modport arbiter (
        input  rd_req, wr_req, addr, wdata,
        output rdata, ack
    );
endinterface

interface fetch_if import rv_pkg::*; ();
    logic   instr_valid;
    instr_t instr;
    word_t  pc;
    logic   redirect;
    word_t  next_pc;

    modport fetch (
        output instr_valid, instr, pc,
        input  redirect, next_pc
    );

    modport exec (
        input  instr_valid, instr, pc,
        output redirect, next_pc
    );
endinterface

// req and done are one-cycle strobes
interface lsu_if import rv_pkg::*; ();
    logic  req;
    logic  we;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  done;

    modport master (
        output req, we, addr, wdata,
        input  rdata, done
    );

    modport slave (
        input  req, we, addr, wdata,
        output rdata, done
    );
endinterface

interface rf_if import rv_pkg::*; ();
    reg_sel_t rs1_sel;
    reg_sel_t rs2_sel;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     wr_en;
    reg_sel_t wr_sel;
    word_t    wr_data;

    modport master (
        output rs1_sel, rs2_sel, wr_en, wr_sel, wr_data,
        input  rs1_data, rs2_data
    );

    modport file (
        input  rs1_sel, rs2_sel, wr_en, wr_sel, wr_data,
        output rs1_data, rs2_data
    );
endinterface

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         halt,
    fetch_if.fetch       fetch,
    mem_bus_if.requester bus
);
    typedef enum logic [1:0] {st_idle, st_req, st_deliver} state_e;

    state_e state;
    word_t  pc_q;
    logic   boot_q;
    instr_t instr_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= st_idle;
            pc_q   <= reset_pc;
            boot_q <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    // first fetch after reset, then one per redirect
                    if (!halt && (boot_q || fetch.redirect)) begin
                        state  <= st_req;
                        boot_q <= 1'b0;
                        if (fetch.redirect) begin
                            pc_q <= fetch.next_pc;
                        end
                    end
                end
                st_req: begin
                    if (bus.ack) begin
                        state <= st_deliver;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_req && bus.ack) begin
            instr_q <= bus.rdata;
        end
    end

    assign bus.rd_req = (state == st_req);
    assign bus.wr_req = 1'b0;
    assign bus.addr   = pc_q;
    assign bus.wdata  = '0;

    assign fetch.instr_valid = (state == st_deliver);
    assign fetch.instr       = instr_q;
    assign fetch.pc          = pc_q;

endmodule

`default_nettype wire

// File: hw/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    fetch_if.exec fetch,
    lsu_if.master lsu,
    rf_if.master  rf,
    output logic  bad_op
);
    typedef enum logic [1:0] {st_idle, st_exec, st_mem, st_next} state_e;

    state_e     state;
    instr_t     instr_q;
    word_t      pc_q;
    word_t      rs1, rs2;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t      alu_b, alu_res, wb_res, target;
    logic [4:0] shamt;
    logic       alt, take;
    logic       is_load, is_store, writes_rd, known_op;

    assign rs1 = rf.rs1_data;
    assign rs2 = rf.rs2_data;

    // sign-extended immediates, one per format
    assign imm_i = {{20{instr_q.i.imm[11]}}, instr_q.i.imm};
    assign imm_s = {{20{instr_q.s.imm_hi[6]}}, instr_q.s.imm_hi, instr_q.s.imm_lo};
    assign imm_b = {{19{instr_q.b.imm_12}}, instr_q.b.imm_12, instr_q.b.imm_11,
                    instr_q.b.imm_10_5, instr_q.b.imm_4_1, 1'b0};
    assign imm_u = {instr_q.u.imm, 12'b0};
    assign imm_j = {{11{instr_q.j.imm_20}}, instr_q.j.imm_20, instr_q.j.imm_19_12,
                    instr_q.j.imm_11, instr_q.j.imm_10_1, 1'b0};

    assign alu_b = (instr_q.r.opcode == op) ? rs2 : imm_i;
    assign shamt = alu_b[4:0];
    // for srai the funct7 bits sit in the top of the i immediate
    assign alt   = (instr_q.r.funct7 == f7_alt);

    always_comb begin
        case (instr_q.r.funct3)
            f3_add_sub: alu_res = (instr_q.r.opcode == op && alt) ? rs1 - alu_b : rs1 + alu_b;
            f3_sll:     alu_res = rs1 << shamt;
            f3_slt:     alu_res = {31'b0, $signed(rs1) < $signed(alu_b)};
            f3_sltu:    alu_res = {31'b0, rs1 < alu_b};
            f3_xor:     alu_res = rs1 ^ alu_b;
            f3_or:      alu_res = rs1 | alu_b;
            f3_and:     alu_res = rs1 & alu_b;
            default: begin
                if (alt) begin
                    alu_res = $signed(rs1) >>> shamt;
                end else begin
                    alu_res = rs1 >> shamt;
                end
            end
        endcase
    end

    always_comb begin
        case (instr_q.b.funct3)
            f3_beq:  take = (rs1 == rs2);
            f3_bne:  take = (rs1 != rs2);
            f3_blt:  take = ($signed(rs1) < $signed(rs2));
            f3_bge:  take = ($signed(rs1) >= $signed(rs2));
            f3_bltu: take = (rs1 < rs2);
            f3_bgeu: take = (rs1 >= rs2);
            default: take = 1'b0;
        endcase
    end

    // opcode decode, result and next pc
    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        writes_rd = 1'b0;
        known_op  = 1'b1;
        wb_res    = alu_res;
        target    = pc_q + 32'd4;
        case (instr_q.r.opcode)
            op_imm, op: writes_rd = 1'b1;
            lui: begin
                writes_rd = 1'b1;
                wb_res    = imm_u;
            end
            auipc: begin
                writes_rd = 1'b1;
                wb_res    = pc_q + imm_u;
            end
            jal: begin
                writes_rd = 1'b1;
                wb_res    = pc_q + 32'd4;
                target    = pc_q + imm_j;
            end
            jalr: begin
                writes_rd = 1'b1;
                wb_res    = pc_q + 32'd4;
                target    = (rs1 + imm_i) & ~32'd1;
            end
            branch: begin
                if (take) begin
                    target = pc_q + imm_b;
                end
            end
            load:    is_load = 1'b1;
            store:   is_store = 1'b1;
            default: known_op = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= st_idle;
            bad_op <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (fetch.instr_valid) begin
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    if (!known_op) begin
                        bad_op <= 1'b1;
                        state  <= st_idle;
                    end else if (is_load || is_store) begin
                        state <= st_mem;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_mem: begin
                    if (lsu.done) begin
                        state <= st_next;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && fetch.instr_valid) begin
            instr_q <= fetch.instr;
            pc_q    <= fetch.pc;
        end
    end

    assign lsu.req   = (state == st_exec) && (is_load || is_store);
    assign lsu.we    = is_store;
    assign lsu.addr  = rs1 + (is_store ? imm_s : imm_i);
    assign lsu.wdata = rs2;

    assign rf.rs1_sel = instr_q.r.rs1;
    assign rf.rs2_sel = instr_q.r.rs2;
    assign rf.wr_sel  = instr_q.r.rd;
    assign rf.wr_en   = ((state == st_exec) && writes_rd)
                     || ((state == st_mem) && lsu.done && is_load);
    assign rf.wr_data = (state == st_mem) ? lsu.rdata : wb_res;

    // memory ops redirect one cycle after done
    assign fetch.redirect = ((state == st_exec) && known_op && !is_load && !is_store)
                         || (state == st_next);
    assign fetch.next_pc  = target;

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
    input  logic clk,
    input  logic rst,
    rf_if.file   rf
);
    word_t regs [num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wr_en && rf.wr_sel != '0) begin
            regs[rf.wr_sel] <= rf.wr_data;
        end
    end

    // x0 reads as zero
    assign rf.rs1_data = (rf.rs1_sel == '0) ? '0 : regs[rf.rs1_sel];
    assign rf.rs2_data = (rf.rs2_sel == '0) ? '0 : regs[rf.rs2_sel];

endmodule

`default_nettype wire

// File: hw/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu import rv_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    lsu_if.slave         req_port,
    mem_bus_if.requester bus,
    output word_t        out,
    output logic         out_en,
    output logic         halt
);
    logic  busy_q;
    logic  done_q;
    logic  we_q;
    word_t addr_q;
    word_t wdata_q;
    word_t rdata_q;
    logic  to_out;
    logic  to_halt;

    assign to_out  = req_port.we && (req_port.addr == out_addr);
    assign to_halt = req_port.we && (req_port.addr == halt_addr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            out_en <= 1'b0;
            halt   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            out_en <= 1'b0;
            if (req_port.req) begin
                // mapped stores finish in one cycle
                if (to_out) begin
                    out_en <= 1'b1;
                    done_q <= 1'b1;
                end else if (to_halt) begin
                    halt   <= 1'b1;
                    done_q <= 1'b1;
                end else begin
                    busy_q <= 1'b1;
                end
            end else if (busy_q && bus.ack) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_port.req) begin
            we_q    <= req_port.we;
            addr_q  <= req_port.addr;
            wdata_q <= req_port.wdata;
        end
        if (req_port.req && to_out) begin
            out <= req_port.wdata;
        end
        if (busy_q && bus.ack) begin
            rdata_q <= bus.rdata;
        end
    end

    assign bus.rd_req = busy_q && !we_q;
    assign bus.wr_req = busy_q && we_q;
    assign bus.addr   = addr_q;
    assign bus.wdata  = wdata_q;

    assign req_port.done  = done_q;
    assign req_port.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hw/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    mem_bus_if.arbiter data_bus,
    mem_bus_if.arbiter fetch_bus,
    output word_t      mem_addr,
    output word_t      mem_wr_data,
    output logic       mem_rd_req,
    output logic       mem_wr_req,
    input  word_t      mem_rd_data,
    input  logic       mem_ack
);
    logic busy_q;
    logic owner_data_q;
    logic data_active;
    logic fetch_active;
    logic sel_data;

    assign data_active  = data_bus.rd_req | data_bus.wr_req;
    assign fetch_active = fetch_bus.rd_req | fetch_bus.wr_req;

    // load/store wins a fresh grant, an open grant holds until ack
    assign sel_data = busy_q ? owner_data_q : data_active;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q       <= 1'b0;
            owner_data_q <= 1'b0;
        end else if (mem_ack) begin
            busy_q <= 1'b0;
        end else if (!busy_q && (data_active || fetch_active)) begin
            busy_q       <= 1'b1;
            owner_data_q <= data_active;
        end
    end

    assign mem_rd_req  = sel_data ? data_bus.rd_req : fetch_bus.rd_req;
    assign mem_wr_req  = sel_data ? data_bus.wr_req : fetch_bus.wr_req;
    assign mem_addr    = sel_data ? data_bus.addr : fetch_bus.addr;
    assign mem_wr_data = sel_data ? data_bus.wdata : fetch_bus.wdata;

    assign data_bus.ack    = sel_data && mem_ack;
    assign fetch_bus.ack   = !sel_data && mem_ack;
    assign data_bus.rdata  = sel_data ? mem_rd_data : '0;
    assign fetch_bus.rdata = sel_data ? '0 : mem_rd_data;

endmodule

`default_nettype wire

// File: hw/proc_top.sv
`timescale 1ns/1ps
`default_nettype none

module proc_top import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    output word_t mem_addr,
    output word_t mem_wr_data,
    output logic  mem_rd_req,
    output logic  mem_wr_req,
    input  word_t mem_rd_data,
    input  logic  mem_ack,
    output word_t out,
    output logic  out_en,
    output logic  halt,
    output word_t pc
);
    logic lsu_halt;
    logic bad_op;

    mem_bus_if fetch_bus ();
    mem_bus_if data_bus ();
    fetch_if   fetch_ch ();
    lsu_if     lsu_ch ();
    rf_if      rf_ch ();

    // either a halt store or an unknown opcode stops the core
    assign halt = lsu_halt | bad_op;
    assign pc   = fetch_ch.pc;

    fetch_unit u_fetch (
        .clk   (clk),
        .rst   (rst),
        .halt  (halt),
        .fetch (fetch_ch),
        .bus   (fetch_bus)
    );

    exec_unit u_exec (
        .clk    (clk),
        .rst    (rst),
        .fetch  (fetch_ch),
        .lsu    (lsu_ch),
        .rf     (rf_ch),
        .bad_op (bad_op)
    );

    reg_file u_rf (
        .clk (clk),
        .rst (rst),
        .rf  (rf_ch)
    );

    lsu u_lsu (
        .clk      (clk),
        .rst      (rst),
        .req_port (lsu_ch),
        .bus      (data_bus),
        .out      (out),
        .out_en   (out_en),
        .halt     (lsu_halt)
    );

    mem_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .data_bus    (data_bus),
        .fetch_bus   (fetch_bus),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack)
    );

endmodule

`default_nettype wire

// File: verification/proc_sva.sv
`timescale 1ns/1ps
`default_nettype none

module proc_sva import rv_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  mem_rd_req,
    input logic  mem_wr_req,
    input logic  mem_ack,
    input word_t mem_addr,
    input logic  halt
);
    int fail_count = 0;

    // an unanswered request keeps its kind and address
    a_rd_held: assert property (@(posedge clk) disable iff (rst)
        mem_rd_req && !mem_ack |=> mem_rd_req && $stable(mem_addr))
        else begin
            $error("read request dropped or moved before mem_ack");
            fail_count++;
        end

    a_wr_held: assert property (@(posedge clk) disable iff (rst)
        mem_wr_req && !mem_ack |=> mem_wr_req && $stable(mem_addr))
        else begin
            $error("write request dropped or moved before mem_ack");
            fail_count++;
        end

    // halt is sticky until reset
    a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
        else begin
            $error("halt fell while rst was low");
            fail_count++;
        end

endmodule

bind proc_top proc_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .mem_rd_req (mem_rd_req),
    .mem_wr_req (mem_wr_req),
    .mem_ack    (mem_ack),
    .mem_addr   (mem_addr),
    .halt       (halt)
);

`default_nettype wire

// File: verification/proc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module proc_tb import rv_pkg::*; ();
    localparam int num_tests    = 5;
    localparam int max_words    = 32;
    localparam int max_outs     = 16;
    localparam int mem_words    = 256;
    localparam int reset_cycles = 8;

    logic  clk;
    logic  rst;
    word_t mem_addr;
    word_t mem_wr_data;
    logic  mem_rd_req;
    logic  mem_wr_req;
    word_t mem_rd_data;
    logic  mem_ack;
    word_t out;
    logic  out_en;
    logic  halt;
    word_t pc;

    word_t  mem [mem_words];
    word_t  prog_tab [num_tests][max_words];
    int     prog_len [num_tests];
    word_t  exp_tab [num_tests][max_outs];
    int     exp_len [num_tests];
    word_t  stop_pc [num_tests];
    string  test_name [num_tests] = '{"alu", "branch", "jump", "load_store", "bad_opcode"};
    int     cur;
    integer seed;
    logic   pending;
    int     wait_left;
    int     cycles;
    int     cycle_limit;
    int     passed;
    int     failed;

    proc_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .out         (out),
        .out_en      (out_en),
        .halt        (halt),
        .pc          (pc)
    );

    always #5 clk = ~clk;

    // memory model answers after 0 to 3 wait cycles with a one-cycle ack
    always @(posedge clk) begin
        #1;
        if (mem_ack) begin
            mem_ack = 1'b0;
            pending = 1'b0;
        end else if (mem_rd_req || mem_wr_req) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = {$random(seed)} % 4;
            end
            if (wait_left == 0) begin
                mem_ack = 1'b1;
                if (mem_wr_req) begin
                    mem[mem_addr[9:2]] = mem_wr_data;
                end else begin
                    mem_rd_data = mem[mem_addr[9:2]];
                end
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, a program never reached halt", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // small assembler for the program table
    function automatic word_t asm_i(input logic [11:0] imm, input reg_sel_t rs1,
                                    input logic [2:0] f3, input reg_sel_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t asm_r(input logic [6:0] f7, input reg_sel_t rs2,
                                    input reg_sel_t rs1, input logic [2:0] f3,
                                    input reg_sel_t rd);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic word_t asm_s(input logic [11:0] imm, input reg_sel_t rs2,
                                    input reg_sel_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], store};
    endfunction

    function automatic word_t asm_b(input logic [12:0] imm, input reg_sel_t rs2,
                                    input reg_sel_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], branch};
    endfunction

    function automatic word_t asm_u(input logic [19:0] imm, input reg_sel_t rd,
                                    input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t asm_j(input logic [20:0] imm, input reg_sel_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, jal};
    endfunction

    task automatic emit(input word_t w);
        prog_tab[cur][prog_len[cur]] = w;
        prog_len[cur]++;
    endtask

    task automatic want(input word_t v);
        exp_tab[cur][exp_len[cur]] = v;
        exp_len[cur]++;
    endtask

    task automatic emit_out(input reg_sel_t rs);
        emit(asm_s(out_addr[11:0], rs, 5'd0));
    endtask

    task automatic emit_halt();
        emit(asm_s(halt_addr[11:0], 5'd0, 5'd0));
    endtask

    task automatic build_tests();
        logic [2:0] conds [6] = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
        // with x1 = -1 and x2 = 1, signed and unsigned order disagree
        logic [5:0] taken = 6'b100110;
        for (int t = 0; t < num_tests; t++) begin
            prog_len[t] = 0;
            exp_len[t]  = 0;
        end
        // alu ops on x1 = -5 and x2 = 3
        cur = 0;
        emit(asm_i(-5, 0, f3_add_sub, 1, op_imm));
        emit(asm_i(3, 0, f3_add_sub, 2, op_imm));
        emit(asm_r(f7_alt, 1, 2, f3_add_sub, 3));
        emit_out(3);
        want(32'd8);
        emit(asm_r(7'd0, 2, 1, f3_slt, 4));
        emit_out(4);
        want(32'd1);
        emit(asm_r(7'd0, 2, 1, f3_sltu, 5));
        emit_out(5);
        want(32'd0);
        emit(asm_i(12'h401, 1, f3_srl_sra, 6, op_imm));
        emit_out(6);
        want(32'hfffffffd);
        emit(asm_i(12'h001, 1, f3_srl_sra, 7, op_imm));
        emit_out(7);
        want(32'h7ffffffd);
        emit(asm_i(5, 0, f3_add_sub, 0, op_imm));
        emit_out(0);
        want(32'd0);
        emit(asm_i(15, 1, f3_xor, 8, op_imm));
        emit_out(8);
        want(32'hfffffff4);
        emit(asm_r(7'd0, 2, 2, f3_sll, 9));
        emit_out(9);
        want(32'd24);
        emit(asm_r(f7_alt, 2, 1, f3_srl_sra, 10));
        emit_out(10);
        want(32'hffffffff);
        emit(asm_i(12'h0f0, 1, f3_and, 11, op_imm));
        emit_out(11);
        want(32'h000000f0);
        emit_halt();
        // each branch skips the not-taken marker when taken
        cur = 1;
        emit(asm_i(-1, 0, f3_add_sub, 1, op_imm));
        emit(asm_i(1, 0, f3_add_sub, 2, op_imm));
        for (int k = 0; k < 6; k++) begin
            emit(asm_i(12'h010 + k, 0, f3_add_sub, 3, op_imm));
            emit(asm_b(13'd8, 2, 1, conds[k]));
            emit(asm_i(12'h020 + k, 0, f3_add_sub, 3, op_imm));
            emit_out(3);
            want(taken[k] ? 32'h10 + k : 32'h20 + k);
        end
        emit_halt();
        // lui, auipc at pc 8, jal at pc 16, jalr at pc 36 to 48
        cur = 2;
        emit(asm_u(20'h12345, 1, lui));
        emit_out(1);
        want(32'h12345000);
        emit(asm_u(20'h00001, 2, auipc));
        emit_out(2);
        want(32'h00001008);
        emit(asm_j(21'd12, 3));
        emit(asm_i(12'h077, 0, f3_add_sub, 4, op_imm));
        emit_out(4);
        emit_out(3);
        want(32'd20);
        emit(asm_i(49, 0, f3_add_sub, 5, op_imm));
        emit(asm_i(0, 5, 3'b000, 6, jalr));
        emit(asm_i(12'h066, 0, f3_add_sub, 4, op_imm));
        emit_out(4);
        emit_out(6);
        want(32'd40);
        emit_halt();
        // store then load back through the memory port
        cur = 3;
        emit(asm_u(20'habcde, 1, lui));
        emit(asm_i(12'h123, 1, f3_add_sub, 1, op_imm));
        emit(asm_i(512, 0, f3_add_sub, 2, op_imm));
        emit(asm_s(12'd4, 1, 2));
        emit(asm_i(-1, 0, f3_add_sub, 3, op_imm));
        emit(asm_s(12'd8, 3, 2));
        emit(asm_i(4, 2, 3'b010, 4, load));
        emit_out(4);
        want(32'habcde123);
        emit(asm_i(8, 2, 3'b010, 5, load));
        emit_out(5);
        want(32'hffffffff);
        emit(asm_r(7'd0, 5, 4, f3_add_sub, 7));
        emit_out(7);
        want(32'habcde122);
        emit_halt();
        // unknown opcode stops the core before the second output
        cur = 4;
        emit(asm_i(7, 0, f3_add_sub, 1, op_imm));
        emit_out(1);
        want(32'd7);
        emit(32'h0000007f);
        emit(asm_i(9, 0, f3_add_sub, 1, op_imm));
        emit_out(1);
        emit_halt();
        // the core stops at its last word, the halt store
        for (int t = 0; t < num_tests; t++) begin
            stop_pc[t] = (prog_len[t] - 1) * 4;
        end
        // the unknown opcode sits in word 2
        stop_pc[4] = 32'd8;
    endtask

    task automatic run_test(input int t);
        word_t got [$];
        int    errs;
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int k = 0; k < mem_words; k++) begin
            mem[k] = {k[23:0], 8'hff};
        end
        for (int k = 0; k < prog_len[t]; k++) begin
            mem[k] = prog_tab[t][k];
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!halt) begin
            @(posedge clk);
            #1;
            if (out_en) begin
                got.push_back(out);
            end
        end
        // a few more cycles so stray outputs after halt show up
        repeat (6) begin
            @(posedge clk);
            #1;
            if (out_en) begin
                got.push_back(out);
            end
        end
        errs = 0;
        assert (got.size() == exp_len[t]) else begin
            $display("test %0d gave %0d outputs where %0d were expected",
                     t, got.size(), exp_len[t]);
            errs++;
        end
        for (int k = 0; k < got.size() && k < exp_len[t]; k++) begin
            assert (got[k] === exp_tab[t][k]) else begin
                $display("Fail at %0t: test %0d output %0d is %h, expected %h",
                         $time, t, k, got[k], exp_tab[t][k]);
                errs++;
            end
        end
        assert (halt === 1'b1) else begin
            $display("test %0d: halt went low again before reset", t);
            errs++;
        end
        assert (pc === stop_pc[t]) else begin
            $display("Fail at %0t: test %0d stopped at pc %h, expected %h",
                     $time, t, pc, stop_pc[t]);
            errs++;
        end
        if (errs == 0) begin
            passed++;
            $display("test %0d %s: passed, %0d outputs", t, test_name[t], got.size());
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", t, test_name[t], errs);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        mem_ack     = 1'b0;
        mem_rd_data = '0;
        seed        = 32'h898b;
        pending     = 1'b0;
        wait_left   = 0;
        cycles      = 0;
        passed      = 0;
        failed      = 0;
        build_tests();
        cycle_limit = 0;
        for (int t = 0; t < num_tests; t++) begin
            cycle_limit += prog_len[t] * 20;
        end
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        assert (u_dut.u_sva.fail_count == 0) else begin
            $display("bus or halt assertions fired %0d times during the run",
                     u_dut.u_sva.fail_count);
        end
        $display("%0d tests run, %0d passed, %0d failed", num_tests, passed, failed);
        if (failed == 0 && u_dut.u_sva.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
common/rv_pkg.sv
common/proc_ifs.sv
hw/fetch_unit.sv
hw/exec_unit.sv
hw/reg_file.sv
hw/lsu.sv
hw/mem_arbiter.sv
hw/proc_top.sv
verification/proc_sva.sv
verification/proc_tb.sv
